/* design/uartPkg.sv */
`default_nettype none

package uartPkg;

    // one character off the serial line
    typedef logic [7:0] byteT;

    typedef enum logic [2:0] {
        idle,
        startBit,
        dataWait,
        dataSample,
        stopBit
    } rxStateT;

endpackage

`default_nettype wire

/* design/loaderPkg.sv */
`default_nettype none

package loaderPkg;

    // instruction word as fetched by the processor
    typedef logic [31:0] wordT;

    // byte address on the fetch port
    typedef logic [7:0] byteAddrT;

    // word index, byte address without its two low bits
    typedef logic [5:0] wordIndexT;

    // depth follows from the width of byteAddrT
    localparam int memWords = 64;

    typedef enum logic [1:0] {
        getLength,
        getByte,
        writeWord,
        done
    } loadStateT;

endpackage

`default_nettype wire

/* design/byteLink.sv */
`timescale 1ns/1ns
`default_nettype none

// one received byte, moved under a four-phase req/ack handshake
interface byteLink
    import uartPkg::*;
();

    logic req;
    logic ack;
    byteT data;
    logic frameError;

    modport sender (output req, output data, output frameError, input ack);

    modport receiver (input req, input data, input frameError, output ack);

endinterface

`default_nettype wire

/* design/uartReceiver.sv */
`timescale 1ns/1ns
`default_nettype none

module uartReceiver
    import uartPkg::*;
#(
    parameter int clocksPerBit = 8
) (
    input  wire       clk,
    input  wire       reset,
    input  wire       rxLine,
    byteLink.sender   link
);

    localparam int timerWidth = $clog2(clocksPerBit + 1);

    localparam logic [timerWidth-1:0] oneCount = timerWidth'(1);
    localparam logic [timerWidth-1:0] halfCount = timerWidth'(clocksPerBit / 2);
    localparam logic [timerWidth-1:0] lastWait = timerWidth'(clocksPerBit - 1);
    localparam logic [timerWidth-1:0] fullCount = timerWidth'(clocksPerBit);

    rxStateT state;
    logic [timerWidth-1:0] bitTimer;
    logic [2:0] bitCount;
    logic [1:0] rxSync;
    logic rxBit;
    byteT shiftReg;
    logic stopSample;
    logic canOffer;

    // line is asynchronous, bring it into the clock domain
    always_ff @(posedge clk) begin
        if (reset) begin
            rxSync <= 2'b11;
        end else begin
            rxSync <= {rxSync[0], rxLine};
        end
    end

    assign rxBit = rxSync[1];

    assign stopSample = (state == stopBit) && (bitTimer == fullCount);

    // a byte still waiting for its ack means the new one is dropped
    assign canOffer = !link.req && !link.ack;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= idle;
            bitTimer <= '0;
            bitCount <= '0;
            link.req <= 1'b0;
        end else begin
            if (link.req && link.ack) begin
                link.req <= 1'b0;
            end

            case (state)
                idle: begin
                    if (!rxBit) begin
                        state <= startBit;
                        bitTimer <= oneCount;
                    end
                end

                startBit: begin
                    if (bitTimer == halfCount) begin
                        // start bit gone high again, treat as glitch
                        if (rxBit) begin
                            state <= idle;
                        end else begin
                            state <= dataWait;
                            bitTimer <= oneCount;
                            bitCount <= '0;
                        end
                    end else begin
                        bitTimer <= bitTimer + oneCount;
                    end
                end

                dataWait: begin
                    bitTimer <= bitTimer + oneCount;
                    if (bitTimer == lastWait) begin
                        state <= dataSample;
                    end
                end

                dataSample: begin
                    bitTimer <= oneCount;
                    bitCount <= bitCount + 3'd1;
                    if (bitCount == 3'd7) begin
                        state <= stopBit;
                    end else begin
                        state <= dataWait;
                    end
                end

                stopBit: begin
                    if (stopSample) begin
                        state <= idle;
                        if (canOffer) begin
                            link.req <= 1'b1;
                        end
                    end else begin
                        bitTimer <= bitTimer + oneCount;
                    end
                end

                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    // lsb arrives first
    always_ff @(posedge clk) begin
        if (state == dataSample) begin
            shiftReg <= {rxBit, shiftReg[7:1]};
        end
        if (stopSample && canOffer) begin
            link.data <= shiftReg;
            link.frameError <= !rxBit;
        end
    end

endmodule

`default_nettype wire

/* design/programLoader.sv */
`timescale 1ns/1ns
`default_nettype none

module programLoader
    import loaderPkg::*;
    import uartPkg::*;
(
    input  wire         clk,
    input  wire         reset,
    byteLink.receiver   link,
    output logic        writeEnable,
    output wordIndexT   writeIndex,
    output wordT        writeData,
    output logic        cpuEnable
);

    loadStateT state;
    byteT wordCount;
    wordIndexT wordIndex;
    logic [1:0] byteCount;
    wordT wordReg;
    logic byteTaken;
    logic goodByte;
    logic lastWord;

    // byte is taken on the edge that raises ack
    assign byteTaken = link.req && !link.ack;
    assign goodByte = byteTaken && !link.frameError;

    assign lastWord = ({2'b00, wordIndex} + 8'd1) == wordCount;

    // ack follows req one cycle later, in both directions
    always_ff @(posedge clk) begin
        if (reset) begin
            link.ack <= 1'b0;
        end else begin
            link.ack <= link.req;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= getLength;
            wordCount <= '0;
            wordIndex <= '0;
            byteCount <= '0;
        end else begin
            case (state)
                getLength: begin
                    if (goodByte) begin
                        wordCount <= link.data;
                        if (link.data == 8'd0) begin
                            state <= done;
                        end else begin
                            state <= getByte;
                        end
                    end
                end

                getByte: begin
                    if (goodByte) begin
                        byteCount <= byteCount + 2'd1;
                        if (byteCount == 2'd3) begin
                            state <= writeWord;
                        end
                    end
                end

                writeWord: begin
                    wordIndex <= wordIndex + 6'd1;
                    if (lastWord) begin
                        state <= done;
                    end else begin
                        state <= getByte;
                    end
                end

                // stays here until reset, late bytes are only acked
                done: begin
                    state <= done;
                end

                default: begin
                    state <= getLength;
                end
            endcase
        end
    end

    // first byte of a word ends up in the top byte
    always_ff @(posedge clk) begin
        if (state == getByte && goodByte) begin
            wordReg <= {wordReg[23:0], link.data};
        end
    end

    assign writeEnable = (state == writeWord);
    assign writeIndex = wordIndex;
    assign writeData = wordReg;
    assign cpuEnable = (state == done);

endmodule

`default_nettype wire

/* design/instructionMemory.sv */
`timescale 1ns/1ns
`default_nettype none

module instructionMemory
    import loaderPkg::*;
(
    input  wire             clk,
    input  wire             writeEnable,
    input  wire wordIndexT  writeIndex,
    input  wire wordT       writeData,
    input  wire byteAddrT   fetchAddress,
    output wordT            fetchData
);

    wordT memory [memWords];
    wordIndexT indexA;
    wordIndexT indexB;
    wordT wordA;
    wordT wordB;

    always_ff @(posedge clk) begin
        if (writeEnable) begin
            memory[writeIndex] <= writeData;
        end
    end

    assign indexA = fetchAddress[7:2];
    // wraps around the top of memory
    assign indexB = indexA + 6'd1;

    assign wordA = memory[indexA];
    assign wordB = memory[indexB];

    // unaligned fetch takes the top of A as low bytes, B fills above
    always_comb begin
        case (fetchAddress[1:0])
            2'd0: fetchData = wordA;
            2'd1: fetchData = {wordB[23:0], wordA[31:24]};
            2'd2: fetchData = {wordB[15:0], wordA[31:16]};
            default: fetchData = {wordB[7:0], wordA[31:8]};
        endcase
    end

endmodule

`default_nettype wire

/* design/bootLoaderTop.sv */
`timescale 1ns/1ns
`default_nettype none

module bootLoaderTop
    import loaderPkg::*;
#(
    parameter int clocksPerBit = 8
) (
    input  wire             clk,
    input  wire             reset,
    input  wire             rxLine,
    input  wire byteAddrT   fetchAddress,
    output wordT            fetchData,
    output logic            cpuEnable
);

    logic writeEnable;
    wordIndexT writeIndex;
    wordT writeData;

    byteLink link0 ();

    uartReceiver #(
        .clocksPerBit (clocksPerBit)
    ) receiver0 (
        .clk    (clk),
        .reset  (reset),
        .rxLine (rxLine),
        .link   (link0)
    );

    programLoader loader0 (
        .clk         (clk),
        .reset       (reset),
        .link        (link0),
        .writeEnable (writeEnable),
        .writeIndex  (writeIndex),
        .writeData   (writeData),
        .cpuEnable   (cpuEnable)
    );

    instructionMemory memory0 (
        .clk          (clk),
        .writeEnable  (writeEnable),
        .writeIndex   (writeIndex),
        .writeData    (writeData),
        .fetchAddress (fetchAddress),
        .fetchData    (fetchData)
    );

endmodule

`default_nettype wire

/* sim/byteLink_properties.sv */
`timescale 1ns/1ns
`default_nettype none

module byteLinkProperties
    import uartPkg::*;
(
    input wire       clk,
    input wire       reset,
    input wire       req,
    input wire       ack,
    input wire byteT data,
    input wire       frameError,
    input wire       cpuEnable
);

    int failCount = 0;

    // sender drops req only after the loader answered
    reqHeldUntilAck: assert property (@(posedge clk) disable iff (reset)
        $fell(req) |-> $past(ack))
    else begin
        $error("req fell before ack was seen");
        failCount++;
    end

    ackAfterReq: assert property (@(posedge clk) disable iff (reset)
        $rose(ack) |-> $past(req))
    else begin
        $error("ack rose without a preceding req");
        failCount++;
    end

    // byte and its flag frozen while waiting for ack
    dataStableWhileOffered: assert property (@(posedge clk) disable iff (reset)
        (req && !ack) |=> $stable({data, frameError}))
    else begin
        $error("data or frameError changed while req was waiting for ack");
        failCount++;
    end

    cpuEnableSticky: assert property (@(posedge clk)
        $fell(cpuEnable) |-> (reset || $past(reset)))
    else begin
        $error("cpuEnable fell outside of reset");
        failCount++;
    end

endmodule

bind programLoader byteLinkProperties props0 (
    .clk        (clk),
    .reset      (reset),
    .req        (link.req),
    .ack        (link.ack),
    .data       (link.data),
    .frameError (link.frameError),
    .cpuEnable  (cpuEnable)
);

`default_nettype wire

/* sim/bootLoaderTb.sv */
`timescale 1ns/1ns
`default_nettype none

module bootLoaderTb
    import loaderPkg::*;
    import uartPkg::*;
();

    localparam int bitClocks = 8;
    // length bytes, data bytes, the bad byte and the four late bytes
    localparam int totalFrames = 17 + 14 + 4 + 41;
    localparam int timeoutCycles = (totalFrames * 11 * bitClocks + 500) * 2;

    logic clk;
    logic reset;
    logic rxLine;
    byteAddrT fetchAddress;
    wordT fetchData;
    logic cpuEnable;

    int errorCount = 0;
    int checkCount = 0;
    int cycleCount = 0;
    byteT progBytes[$];
    // memory is never cleared, so the model keeps old loads too
    wordT modelMem [memWords];

    bootLoaderTop #(
        .clocksPerBit (bitClocks)
    ) dut0 (
        .clk          (clk),
        .reset        (reset),
        .rxLine       (rxLine),
        .fetchAddress (fetchAddress),
        .fetchData    (fetchData),
        .cpuEnable    (cpuEnable)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= timeoutCycles) begin
            $display("timeout, the run did not finish within %0d cycles", timeoutCycles);
            $display("** FAIL **");
            $finish;
        end
    end

    task automatic checkWord(input string name, input wordT actual, input wordT expected);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("error at %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic checkBit(input string name, input logic actual, input logic expected);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("error at %0t: %s expected %b, got %b", $time, name, expected, actual);
        end
    endtask

    task automatic applyReset();
        @(posedge clk);
        #1;
        reset = 1'b1;
        rxLine = 1'b1;
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;
    endtask

    task automatic holdLine(input logic value);
        rxLine = value;
        repeat (bitClocks) @(posedge clk);
        #1;
    endtask

    // one 8N1 frame, lsb first
    task automatic sendByte(input byteT data, input bit badStop);
        @(posedge clk);
        #1;
        holdLine(1'b0);
        for (int i = 0; i < 8; i++) begin
            holdLine(data[i]);
        end
        holdLine(!badStop);
        holdLine(1'b1);
    endtask

    task automatic waitForEnable();
        int waited;
        waited = 0;
        while (!cpuEnable && waited < 4 * bitClocks) begin
            @(posedge clk);
            #1;
            waited++;
        end
        checkCount++;
        if (!cpuEnable) begin
            errorCount++;
            $display("cpuEnable did not rise after the last word of the program was sent");
        end
    endtask

    // a bad byte goes out just before the data byte at badPosition
    task automatic loadProgram(input int words, input int badPosition);
        sendByte(byteT'(words), 1'b0);
        foreach (progBytes[i]) begin
            if (i == badPosition) begin
                sendByte(8'hC3, 1'b1);
            end
            if (i == progBytes.size() - 1) begin
                checkBit("cpuEnable", cpuEnable, 1'b0);
            end
            sendByte(progBytes[i], 1'b0);
        end
        waitForEnable();
        for (int w = 0; w < words; w++) begin
            modelMem[w] = {progBytes[4 * w], progBytes[4 * w + 1],
                           progBytes[4 * w + 2], progBytes[4 * w + 3]};
        end
    endtask

    function automatic wordT expectedFetch(input byteAddrT address);
        int index;
        int offset;
        logic [63:0] pair;
        index = int'(address) / 4;
        offset = int'(address) % 4;
        pair = {modelMem[(index + 1) % memWords], modelMem[index]};
        if (offset == 0) begin
            return modelMem[index];
        end
        // next word above, wanted bytes shifted to the bottom
        return wordT'(pair >> (8 * (4 - offset)));
    endfunction

    task automatic checkFetch(input byteAddrT address);
        @(posedge clk);
        #1;
        fetchAddress = address;
        #1;
        checkWord($sformatf("fetchData[%02h]", address), fetchData, expectedFetch(address));
    endtask

    task automatic checkAligned(input int words);
        for (int w = 0; w < words; w++) begin
            checkFetch(byteAddrT'(4 * w));
        end
    endtask

    // both neighbouring words must be loaded
    task automatic checkUnaligned(input int lastIndex);
        for (int w = 0; w < lastIndex; w++) begin
            for (int offset = 1; offset < 4; offset++) begin
                checkFetch(byteAddrT'(4 * w + offset));
            end
        end
    endtask

    task automatic testResetAndLoad();
        applyReset();
        checkBit("cpuEnable", cpuEnable, 1'b0);
        progBytes.delete();
        for (int i = 0; i < 16; i++) begin
            progBytes.push_back(byteT'(60 + 29 * i));
        end
        loadProgram(4, -1);
        checkBit("cpuEnable", cpuEnable, 1'b1);
    endtask

    task automatic testFramingError();
        applyReset();
        checkBit("cpuEnable", cpuEnable, 1'b0);
        progBytes.delete();
        for (int i = 0; i < 12; i++) begin
            progBytes.push_back(byteT'(160 + 7 * i));
        end
        // lands in the middle of word 1
        loadProgram(3, 6);
        checkBit("cpuEnable", cpuEnable, 1'b1);
        checkAligned(3);
        checkUnaligned(2);
    endtask

    // a full word's worth of late bytes, led by a nonzero count
    task automatic testAfterDone();
        sendByte(8'h01, 1'b0);
        sendByte(8'hFF, 1'b0);
        sendByte(8'h05, 1'b0);
        sendByte(8'hA7, 1'b0);
        checkBit("cpuEnable", cpuEnable, 1'b1);
        checkAligned(4);
    endtask

    task automatic testRandomProgram();
        int index;
        int offset;
        applyReset();
        progBytes.delete();
        for (int i = 0; i < 40; i++) begin
            progBytes.push_back(byteT'($urandom));
        end
        loadProgram(10, -1);
        checkBit("cpuEnable", cpuEnable, 1'b1);
        checkAligned(10);
        repeat (20) begin
            index = $urandom % 9;
            offset = 1 + $urandom % 3;
            checkFetch(byteAddrT'(4 * index + offset));
        end
    endtask

    initial begin
        int assertFails;
        reset = 1'b1;
        rxLine = 1'b1;
        fetchAddress = '0;
        void'($urandom(52856));

        testResetAndLoad();
        checkAligned(4);
        checkUnaligned(3);
        testFramingError();
        testAfterDone();
        testRandomProgram();

        assertFails = dut0.loader0.props0.failCount;
        $display("checks %0d, errors %0d, assertion failures %0d",
                 checkCount, errorCount, assertFails);
        if (errorCount == 0 && assertFails == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
design/uartPkg.sv
design/loaderPkg.sv
design/byteLink.sv
design/uartReceiver.sv
design/programLoader.sv
design/instructionMemory.sv
design/bootLoaderTop.sv
sim/byteLink_properties.sv
sim/bootLoaderTb.sv

/* run.sh */
#!/bin/sh
# build and run the boot loader testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module bootLoaderTb \
    -f sources.f -Mdir obj_dir -o bootLoaderSim

# keep running after an assertion error so the testbench reaches its verdict
./obj_dir/bootLoaderSim +verilator+error+limit+1000 | tee sim.log

if grep -qx '\*\* PASS \*\*' sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi
